// ==== design/memsys_pkg.sv ====
package memsys_pkg;

    // where the controller takes the access address from
    typedef enum logic [2:0] {
        SRC_PC   = 3'd0, // opcode fetch at pc
        SRC_OPD  = 3'd1, // operand byte or word at pc
        SRC_X    = 3'd2, // x register as pointer
        SRC_Y    = 3'd3, // y register as pointer
        SRC_PUSH = 3'd4, // stack push, sp grows down
        SRC_IDX  = 3'd5  // x plus signed offset
    } addr_sel_e;

    // reg_sel codes for loading the pointer registers
    localparam logic [1:0] REG_X  = 2'd0;
    localparam logic [1:0] REG_Y  = 2'd1;
    localparam logic [1:0] REG_SP = 2'd2;

    // one access request from the control unit
    typedef struct packed {
        logic              valid;
        addr_sel_e         src;
        logic              wide;    // two bytes, big-endian
        logic              wr;
        logic signed [7:0] idx_ofs; // only for SRC_IDX
        logic [15:0]       wdata;   // byte writes take [7:0]
    } mem_req_t;

    // result back to the control unit
    typedef struct packed {
        logic        done;  // one clk pulse
        logic        is_op; // last access was an opcode fetch
        logic [7:0]  op;
        logic [15:0] data;  // byte reads come zero-extended
    } mem_rsp_t;

    // vector locations, each holds a big-endian pc
    localparam logic [15:0] VEC_FIRQ = 16'hFFF6;
    localparam logic [15:0] VEC_IRQ  = 16'hFFF8;
    localparam logic [15:0] VEC_NMI  = 16'hFFFC;
    localparam logic [15:0] VEC_RST  = 16'hFFFE;

    // one-hot interrupt code, zero when nothing pending
    typedef logic [3:0] int_vec_t;

    localparam int_vec_t INT_IRQ  = 4'b0001;
    localparam int_vec_t INT_FIRQ = 4'b0010;
    localparam int_vec_t INT_NMI  = 4'b0100;
    localparam int_vec_t INT_RST  = 4'b1000;

    // vector address for an interrupt code
    // later checks override, so reset wins over nmi and so on
    function automatic logic [15:0] vec_addr(input int_vec_t code);
        logic [15:0] a;
        a = VEC_IRQ;
        if (code[1]) a = VEC_FIRQ;
        if (code[2]) a = VEC_NMI;
        if (code[3]) a = VEC_RST;
        return a;
    endfunction

endpackage

// ==== design/cen_gen.sv ====
`timescale 1ns/1ps

// clock enables for the memory side
// cen2 runs at twice the control unit rate, cen marks every other cen2
module cen_gen #(
    parameter int CEN_DIV = 2 // clk cycles per cen2 pulse
) (
    input  logic clk,
    input  logic rst,
    output logic cen2,
    output logic cen
);

    localparam int CW = (CEN_DIV > 1) ? $clog2(CEN_DIV) : 1;

    logic [CW-1:0] cnt;
    logic          odd; // flips on each cen2

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt  <= '0;
            odd  <= 1'b0;
            cen2 <= 1'b0;
            cen  <= 1'b0;
        end else begin
            cen2 <= 1'b0; // strobes last one clk
            cen  <= 1'b0;
            if (cnt == CW'(CEN_DIV - 1)) begin
                cnt  <= '0;
                cen2 <= 1'b1;
                cen  <= odd; // second of each pair
                odd  <= ~odd;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

// ==== design/addr_src.sv ====
`timescale 1ns/1ps

// pointer registers and the addresses built from them
// everything here is combinational toward the controller except the registers
module addr_src import memsys_pkg::*; #(
    parameter logic [15:0] SP_RESET = 16'h03F0 // stack top after reset
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              reg_we,    // load strobe from the control unit
    input  logic [1:0]        reg_sel,   // REG_X, REG_Y or REG_SP
    input  logic [15:0]       reg_wdata,
    input  logic              push_step, // one per pushed byte
    input  logic signed [7:0] idx_ofs,
    output logic [15:0]       x_addr,
    output logic [15:0]       y_addr,
    output logic [15:0]       push_addr,
    output logic [15:0]       idx_addr
);

    logic [15:0] x_q;
    logic [15:0] y_q;
    logic [15:0] sp_q;
    logic [15:0] ofs_ext; // sign-extended index offset

    // x and y only change on a load
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            x_q <= 16'h0000;
            y_q <= 16'h0000;
        end else if (reg_we) begin
            case (reg_sel)
                REG_X:   x_q <= reg_wdata;
                REG_Y:   y_q <= reg_wdata;
                default: ; // sp handled below, code 3 unused
            endcase
        end
    end

    // stack pointer
    // a load from the control unit takes priority over a push step
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sp_q <= SP_RESET;
        end else if (reg_we && reg_sel == REG_SP) begin
            sp_q <= reg_wdata;
        end else if (push_step) begin
            sp_q <= sp_q - 16'd1; // predecrement, sp points at last pushed byte
        end
    end

    assign ofs_ext = {{8{idx_ofs[7]}}, idx_ofs};

    assign x_addr    = x_q;
    assign y_addr    = y_q;
    assign push_addr = sp_q - 16'd1;  // next free byte below the stack top
    assign idx_addr  = x_q + ofs_ext; // wraps at 64k

endmodule

// ==== design/mem_ctrl.sv ====
`timescale 1ns/1ps

// memory controller
// one request at a time, split into one or two byte phases on cen2
module mem_ctrl import memsys_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen2,      // all state moves on this strobe
    input  logic        cen,       // control unit rate
    input  mem_req_t    req,
    input  logic [15:0] pc,
    input  logic [15:0] x_addr,
    input  logic [15:0] y_addr,
    input  logic [15:0] push_addr,
    input  logic [15:0] idx_addr,
    input  int_vec_t    intvec,
    input  logic [7:0]  bus_din,   // combinational ram read
    output logic [15:0] bus_addr,
    output logic [7:0]  bus_dout,
    output logic        bus_we,
    output logic        push_step,
    output mem_rsp_t    rsp,
    output logic        busy,
    output logic        up_pc      // pc must load rsp.data
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FIRST,  // high byte of a wide access, or the only byte
        ST_SECOND  // low byte at address plus one
    } state_e;

    state_e      state;
    logic        wide_q;   // two byte phases
    logic        wr_q;
    logic        fetch_q;  // opcode fetch, first byte goes to op
    logic        push_q;   // stack write, steps sp per byte
    logic        int_q;    // vector fetch in progress
    logic [7:0]  first_q;  // first byte read
    logic [15:0] sel_addr;
    logic        take_req;
    logic        take_int;
    logic        last_phase;

    // address source mux
    always_comb begin
        case (req.src)
            SRC_X:    sel_addr = x_addr;
            SRC_Y:    sel_addr = y_addr;
            SRC_PUSH: sel_addr = req.wide ? push_addr - 16'd1 : push_addr; // word sits below sp
            SRC_IDX:  sel_addr = idx_addr;
            default:  sel_addr = pc; // SRC_PC and SRC_OPD
        endcase
    end

    // writes start on a cen tick so the strobe lines up with the control unit
    assign take_req = !busy && req.valid && (!req.wr || cen);
    // interrupts only fill a slot with no request
    assign take_int = !busy && !req.valid && (intvec != '0);

    assign last_phase = (state == ST_FIRST && !wide_q) || state == ST_SECOND;

    // sp drops by one on each written stack byte
    assign push_step = cen2 && busy && push_q;

    // sequencing and result
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= ST_IDLE;
            busy    <= 1'b0;
            bus_we  <= 1'b0;
            up_pc   <= 1'b0;
            wide_q  <= 1'b0;
            wr_q    <= 1'b0;
            fetch_q <= 1'b0;
            push_q  <= 1'b0;
            int_q   <= 1'b0;
            rsp     <= '0;
        end else begin
            rsp.done <= 1'b0; // single clk pulse
            if (cen2) begin
                up_pc <= 1'b0; // lasts one cen2 period
                if (take_req || take_int) begin
                    busy    <= 1'b1;
                    state   <= ST_FIRST;
                    bus_we  <= take_req && req.wr;
                    wide_q  <= take_int || req.wide; // vectors are words
                    wr_q    <= take_req && req.wr;
                    fetch_q <= take_req && req.src == SRC_PC && !req.wr;
                    push_q  <= take_req && req.src == SRC_PUSH && req.wr;
                    int_q   <= take_int;
                end else if (state == ST_FIRST && wide_q) begin
                    state <= ST_SECOND; // bus_we stays up for the low byte
                end else if (last_phase) begin
                    state     <= ST_IDLE;
                    busy      <= 1'b0;
                    bus_we    <= 1'b0;
                    up_pc     <= int_q;
                    rsp.done  <= 1'b1;
                    rsp.is_op <= fetch_q;
                    if (fetch_q) begin
                        rsp.op <= wide_q ? first_q : bus_din;
                    end
                    if (!wr_q) begin
                        rsp.data <= wide_q ? {first_q, bus_din} : {8'h00, bus_din};
                    end
                end
            end
        end
    end

    // address and data path
    // the vector address stays on the bus until the next request
    always_ff @(posedge clk) begin
        if (cen2) begin
            if (state == ST_IDLE) begin
                if (take_req) begin
                    bus_addr <= sel_addr;
                    bus_dout <= req.wide ? req.wdata[15:8] : req.wdata[7:0]; // high byte first
                end else if (take_int) begin
                    bus_addr <= vec_addr(intvec);
                end
            end else if (state == ST_FIRST) begin
                first_q <= bus_din;
                if (wide_q) begin
                    bus_addr <= bus_addr + 16'd1;
                    bus_dout <= req.wdata[7:0]; // req is held until done
                end
            end
        end
    end

endmodule

// ==== design/byte_ram.sv ====
`timescale 1ns/1ps

// byte-wide ram
// only the low RAM_AW address bits decode, so higher addresses alias
module byte_ram #(
    parameter int RAM_AW = 10 // 1k bytes by default
) (
    input  logic        clk,
    input  logic [15:0] addr,
    input  logic [7:0]  din,
    input  logic        we,
    output logic [7:0]  dout
);

    localparam int DEPTH = 1 << RAM_AW;

    logic [7:0]        mem [0:DEPTH-1];
    logic [RAM_AW-1:0] a; // decoded part of the address

    assign a = addr[RAM_AW-1:0];

    // start from a known, all zero image
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = 8'h00;
        end
    end

    // write on the clock edge when we is high
    always_ff @(posedge clk) begin
        if (we) begin
            mem[a] <= din;
        end
    end

    // asynchronous read
    // the controller samples it on the following cen2
    assign dout = mem[a];

endmodule

// ==== design/mem_subsys.sv ====
`timescale 1ns/1ps

// memory access subsystem
// ties the strobes, pointer registers, controller and ram together
module mem_subsys import memsys_pkg::*; #(
    parameter int          CEN_DIV  = 2,       // clk cycles per cen2
    parameter int          RAM_AW   = 10,      // ram address bits
    parameter logic [15:0] SP_RESET = 16'h03F0 // stack top after reset
) (
    input  logic        clk,
    input  logic        rst,
    input  mem_req_t    req,
    input  logic [15:0] pc,
    input  int_vec_t    intvec,
    input  logic        reg_we,
    input  logic [1:0]  reg_sel,
    input  logic [15:0] reg_wdata,
    output mem_rsp_t    rsp,
    output logic        busy,
    output logic        up_pc
);

    logic        cen2;
    logic        cen;
    logic [15:0] x_addr;
    logic [15:0] y_addr;
    logic [15:0] push_addr;
    logic [15:0] idx_addr;
    logic        push_step;
    logic [15:0] bus_addr;
    logic [7:0]  bus_dout;  // controller to ram
    logic [7:0]  bus_din;   // ram to controller
    logic        bus_we;

    cen_gen #(.CEN_DIV(CEN_DIV)) cen_gen_i (
        .clk, .rst, .cen2, .cen
    );

    addr_src #(.SP_RESET(SP_RESET)) addr_src_i (
        .clk, .rst, .reg_we, .reg_sel, .reg_wdata, .push_step,
        .idx_ofs (req.idx_ofs), // offset travels with the request
        .x_addr, .y_addr, .push_addr, .idx_addr
    );

    mem_ctrl mem_ctrl_i (
        .clk, .rst, .cen2, .cen, .req, .pc,
        .x_addr, .y_addr, .push_addr, .idx_addr, .intvec, .bus_din,
        .bus_addr, .bus_dout, .bus_we, .push_step, .rsp, .busy, .up_pc
    );

    byte_ram #(.RAM_AW(RAM_AW)) byte_ram_i (
        .clk, .addr(bus_addr), .din(bus_dout), .we(bus_we), .dout(bus_din)
    );

endmodule

// ==== testbench/mem_subsys_tb.sv ====
`timescale 1ns/1ps

// testbench for the memory subsystem
// random requests checked against a byte array model with the same address rules
module mem_subsys_tb import memsys_pkg::*; ();

    localparam int          CEN_DIV  = 2;
    localparam int          RAM_AW   = 10;
    localparam logic [15:0] SP_RESET = 16'h03F0;
    localparam int          DEPTH    = 1 << RAM_AW;

    // loop counts per test
    localparam int N_RW    = 16; // byte write and read pairs
    localparam int N_WIDE  = 6;  // last case wraps at the ram top
    localparam int N_OP    = 6;
    localparam int N_STACK = 4;
    localparam int N_REQ   = 2 + 2 * N_RW + 4 * N_WIDE + 3 * N_OP + 6 * N_STACK + 8 + 2;
    // 3 access ticks, up to 2 more for a cen aligned write, 1 for the handshake
    localparam int LIMIT   = N_REQ * 6 * CEN_DIV + 200;

    logic        clk;
    logic        rst;
    mem_req_t    req;
    logic [15:0] pc;
    int_vec_t    intvec;
    logic        reg_we;
    logic [1:0]  reg_sel;
    logic [15:0] reg_wdata;
    mem_rsp_t    rsp;
    logic        busy;
    logic        up_pc;

    logic [7:0]  ram_mdl [0:DEPTH-1]; // reference memory, aliases like the ram
    logic [15:0] x_mdl;
    logic [15:0] y_mdl;
    logic [15:0] sp_mdl;

    integer      seed;
    int          cycles   = 0;
    int          n_tests  = 0;
    int          n_checks = 0;
    int          n_errors = 0;
    int          t_checks = 0; // current test only
    int          t_errors = 0;

    mem_subsys #(
        .CEN_DIV (CEN_DIV),
        .RAM_AW  (RAM_AW),
        .SP_RESET(SP_RESET)
    ) dut_i (
        .clk, .rst, .req, .pc, .intvec, .reg_we, .reg_sel, .reg_wdata,
        .rsp, .busy, .up_pc
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: the run did not finish within %0d clock cycles", LIMIT);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    function automatic logic [7:0] mdl_rd(input logic [15:0] a);
        return ram_mdl[a[RAM_AW-1:0]]; // upper bits ignored
    endfunction

    task automatic mdl_wr(input logic [15:0] a, input logic [7:0] d);
        ram_mdl[a[RAM_AW-1:0]] = d;
    endtask

    // expected address of the first byte for each source
    function automatic logic [15:0] exp_addr(input addr_sel_e src, input logic wide,
                                             input logic [7:0] ofs);
        case (src)
            SRC_X:    return x_mdl;
            SRC_Y:    return y_mdl;
            SRC_PUSH: return wide ? sp_mdl - 16'd2 : sp_mdl - 16'd1; // below the old top
            SRC_IDX:  return x_mdl + {{8{ofs[7]}}, ofs};
            default:  return pc; // opcode and operand fetches
        endcase
    endfunction

    task automatic check_flag(input string name, input logic got, input logic exp);
        t_checks++;
        if (got !== exp) begin
            $display("FAIL %s: got %h expected %h", name, got, exp);
            t_errors++;
        end
    endtask

    task automatic check_addr(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
        t_checks++;
        if (got !== exp) begin
            $display("FAIL %s: got %h expected %h", name, got, exp);
            t_errors++;
        end
    endtask

    // op only matters on a fetch, data only on a read
    task automatic check_rsp(input string name, input mem_rsp_t got, input mem_rsp_t exp,
                             input logic use_data);
        t_checks++;
        if (got.done !== exp.done) begin
            $display("FAIL %s rsp.done: got %h expected %h", name, got.done, exp.done);
            t_errors++;
        end
        if (got.is_op !== exp.is_op) begin
            $display("FAIL %s rsp.is_op: got %h expected %h", name, got.is_op, exp.is_op);
            t_errors++;
        end
        if (exp.is_op && got.op !== exp.op) begin
            $display("FAIL %s rsp.op: got %h expected %h", name, got.op, exp.op);
            t_errors++;
        end
        if (use_data && got.data !== exp.data) begin
            $display("FAIL %s rsp.data: got %h expected %h", name, got.data, exp.data);
            t_errors++;
        end
    endtask

    task automatic end_test(input string name);
        n_tests++;
        n_checks += t_checks;
        n_errors += t_errors;
        $display("test %0d %s: %0d checks, %0d errors", n_tests, name, t_checks, t_errors);
        t_checks = 0;
        t_errors = 0;
    endtask

    task automatic next_drive_slot();
        @(posedge clk);
        #2; // inputs move just after the edge
    endtask

    task automatic load_reg(input logic [1:0] sel, input logic [15:0] val);
        next_drive_slot();
        reg_we    = 1'b1;
        reg_sel   = sel;
        reg_wdata = val;
        next_drive_slot();
        reg_we = 1'b0;
        case (sel)
            REG_X:   x_mdl = val;
            REG_Y:   y_mdl = val;
            default: sp_mdl = val;
        endcase
    endtask

    // present a request or an interrupt code, hold it until busy drops again
    task automatic issue(input mem_req_t r, input int_vec_t code, output mem_rsp_t got,
                         output logic got_up);
        next_drive_slot();
        req    = r;
        intvec = code;
        @(negedge clk);
        while (busy !== 1'b1) begin
            @(negedge clk); // outputs settle mid cycle
        end
        while (busy !== 1'b0) begin
            @(negedge clk);
        end
        got    = rsp; // done pulses as busy falls
        got_up = up_pc;
        next_drive_slot();
        req    = '0;
        intvec = '0;
    endtask

    // one checked access, the model follows the write
    task automatic access(input addr_sel_e src, input logic wide, input logic wr,
                          input logic [7:0] ofs, input logic [15:0] wdata);
        mem_req_t    r;
        mem_rsp_t    got;
        mem_rsp_t    exp;
        logic        got_up;
        logic [15:0] a;
        a         = exp_addr(src, wide, ofs);
        r         = '0;
        r.valid   = 1'b1;
        r.src     = src;
        r.wide    = wide;
        r.wr      = wr;
        r.idx_ofs = ofs;
        r.wdata   = wdata;
        issue(r, '0, got, got_up);
        exp      = '0;
        exp.done = 1'b1;
        if (wr) begin
            if (wide) begin
                mdl_wr(a, wdata[15:8]); // big-endian
                mdl_wr(a + 16'd1, wdata[7:0]);
            end else begin
                mdl_wr(a, wdata[7:0]);
            end
            if (src == SRC_PUSH) begin
                sp_mdl = a; // sp ends on the lowest pushed byte
            end
        end else begin
            exp.is_op = (src == SRC_PC);
            exp.op    = mdl_rd(a);
            exp.data  = wide ? {mdl_rd(a), mdl_rd(a + 16'd1)} : {8'h00, mdl_rd(a)};
        end
        check_rsp($sformatf("%s %s", src.name(), wr ? "write" : "read"), got, exp, !wr);
        check_flag("up_pc", got_up, 1'b0);
    endtask

    // preload a vector word, then raise the interrupt code
    task automatic take_vector(input int_vec_t code, input logic [15:0] vec);
        mem_req_t    r;
        mem_rsp_t    got;
        mem_rsp_t    exp;
        logic        got_up;
        logic [15:0] word;
        word = $random(seed);
        load_reg(REG_X, vec);
        access(SRC_X, 1'b1, 1'b1, 8'h00, word);
        r = '0; // idle slot
        issue(r, code, got, got_up);
        exp      = '0;
        exp.done = 1'b1;
        exp.data = {mdl_rd(vec), mdl_rd(vec + 16'd1)};
        check_rsp($sformatf("vector %h", vec), got, exp, 1'b1);
        check_flag("up_pc", got_up, 1'b1); // pulses with done
        check_addr("new pc", got.data, word);
    endtask

    initial begin
        mem_req_t    r;
        mem_rsp_t    got;
        mem_rsp_t    exp;
        logic        got_up;
        logic [15:0] a;
        logic [15:0] w;
        logic [7:0]  ofs;
        logic [31:0] rnd;
        addr_sel_e   src;

        seed      = 32'h3578;
        rst       = 1'b1;
        req       = '0;
        pc        = 16'h0000;
        intvec    = '0;
        reg_we    = 1'b0;
        reg_sel   = REG_X;
        reg_wdata = 16'h0000;
        x_mdl     = 16'h0000;
        y_mdl     = 16'h0000;
        sp_mdl    = SP_RESET;
        for (int i = 0; i < DEPTH; i++) begin
            ram_mdl[i] = 8'h00; // ram comes up cleared
        end
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;

        // idle outputs, then a first push lands below the reset stack top
        @(negedge clk);
        check_flag("busy", busy, 1'b0);
        check_flag("bus_we", dut_i.bus_we, 1'b0);
        check_flag("up_pc", up_pc, 1'b0);
        check_flag("rsp.done", rsp.done, 1'b0);
        w = $random(seed);
        access(SRC_PUSH, 1'b0, 1'b1, 8'h00, w);
        load_reg(REG_Y, sp_mdl);
        access(SRC_Y, 1'b0, 1'b0, 8'h00, 16'h0000);
        end_test("reset state");

        load_reg(REG_X, $random(seed));
        load_reg(REG_Y, $random(seed));
        load_reg(REG_SP, $random(seed));
        for (int i = 0; i < N_RW; i++) begin
            rnd = $random(seed);
            case (rnd % 3)
                0:       src = SRC_OPD;
                1:       src = SRC_X;
                default: src = SRC_Y;
            endcase
            pc = $random(seed);
            w  = $random(seed);
            access(src, 1'b0, 1'b1, 8'h00, w);
            access(src, 1'b0, 1'b0, 8'h00, 16'h0000);
        end
        end_test("byte access per source");

        for (int i = 0; i < N_WIDE; i++) begin
            a = $random(seed);
            if (i == N_WIDE - 1) begin
                a[RAM_AW-1:0] = '1; // low byte wraps to ram address 0
            end
            w = $random(seed);
            load_reg(REG_X, a);
            access(SRC_X, 1'b1, 1'b1, 8'h00, w);
            access(SRC_X, 1'b1, 1'b0, 8'h00, 16'h0000);
            access(SRC_X, 1'b0, 1'b0, 8'h00, 16'h0000); // high byte
            load_reg(REG_X, a + 16'd1);
            access(SRC_X, 1'b0, 1'b0, 8'h00, 16'h0000); // low byte
        end
        end_test("wide big-endian");

        for (int i = 0; i < N_OP; i++) begin
            pc = $random(seed);
            w  = $random(seed);
            access(SRC_OPD, 1'b0, 1'b1, 8'h00, w);
            access(SRC_PC, 1'b0, 1'b0, 8'h00, 16'h0000);
            access(SRC_OPD, 1'b0, 1'b0, 8'h00, 16'h0000); // is_op drops again
        end
        end_test("opcode fetch");

        for (int i = 0; i < N_STACK; i++) begin
            w = $random(seed);
            access(SRC_PUSH, 1'b0, 1'b1, 8'h00, w);
            load_reg(REG_Y, sp_mdl);
            access(SRC_Y, 1'b0, 1'b0, 8'h00, 16'h0000);
            w = $random(seed);
            access(SRC_PUSH, 1'b1, 1'b1, 8'h00, w); // sp down by two
            load_reg(REG_Y, sp_mdl);
            access(SRC_Y, 1'b1, 1'b0, 8'h00, 16'h0000);
            load_reg(REG_X, $random(seed));
            ofs = $random(seed);
            w   = $random(seed);
            access(SRC_IDX, 1'b0, 1'b1, ofs, w);
            load_reg(REG_Y, exp_addr(SRC_IDX, 1'b0, ofs)); // read back through y
            access(SRC_Y, 1'b0, 1'b0, 8'h00, 16'h0000);
        end
        end_test("stack push and indexed");

        take_vector(INT_IRQ, VEC_IRQ);
        take_vector(INT_FIRQ, VEC_FIRQ);
        take_vector(INT_NMI, VEC_NMI);
        take_vector(INT_RST, VEC_RST);
        end_test("interrupt vectors");

        // pc and intvec change while a wide operand read is in flight
        a  = $random(seed);
        w  = $random(seed);
        pc = a;
        access(SRC_OPD, 1'b1, 1'b1, 8'h00, w);
        r       = '0;
        r.valid = 1'b1;
        r.src   = SRC_OPD;
        r.wide  = 1'b1;
        next_drive_slot();
        req = r;
        @(negedge clk);
        while (busy !== 1'b1) begin
            @(negedge clk);
        end
        next_drive_slot();
        pc     = ~a;
        intvec = INT_NMI;
        while (busy !== 1'b0) begin
            @(negedge clk);
        end
        got    = rsp;
        got_up = up_pc;
        next_drive_slot();
        req      = '0;
        intvec   = '0;
        exp      = '0;
        exp.done = 1'b1;
        exp.data = {mdl_rd(a), mdl_rd(a + 16'd1)};
        check_rsp("held read", got, exp, 1'b1);
        check_addr("held read rsp.data", got.data, w);
        check_flag("up_pc", got_up, 1'b0); // interrupt waits for an idle slot
        end_test("back-pressure");

        $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== files.f ====
design/memsys_pkg.sv
design/cen_gen.sv
design/addr_src.sv
design/mem_ctrl.sv
design/byte_ram.sv
design/mem_subsys.sv
testbench/mem_subsys_tb.sv
